// ==== design/stats_cfg.svh ====
`ifndef STATS_CFG_SVH
`define STATS_CFG_SVH

// Input sample width
`define STATS_SAMPLE_W 8
// Sum of squares, room for 256 full-scale samples
`define STATS_ENERGY_W 24
// Per-frame sample count, saturates at all ones
`define STATS_COUNT_W 8
// Result FIFO entries
`define STATS_QUEUE_DEPTH 4

`endif

// ==== design/stats_pkg.sv ====
`default_nettype none

`include "stats_cfg.svh"

package stats_pkg;

	// One stream sample
	typedef logic [`STATS_SAMPLE_W-1:0] sample_t;

	// Per-frame statistics, energy in the top bits
	typedef struct packed {
		logic [`STATS_ENERGY_W-1:0] energy;
		sample_t                    peak;
		logic [`STATS_COUNT_W-1:0]  count;
	} result_t;

endpackage

`default_nettype wire

// ==== design/stat_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One broadcast leg from the control stage to a statistics unit
interface stat_bus_if;
	import stats_pkg::*;

	logic    rdy;
	logic    ack;
	sample_t sample;
	// Closes the current frame
	logic    last;

	// Control side holds rdy and data until ack
	modport ctrl (output rdy, output sample, output last, input ack);

	modport unit (input rdy, input sample, input last, output ack);

endinterface

`default_nettype wire

// ==== design/stream_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module stream_ctrl (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_src_rdy,
	output logic               o_src_ack,
	input  stats_pkg::sample_t i_src_sample,
	input  logic               i_src_last,
	stat_bus_if.ctrl           energy_bus,
	stat_bus_if.ctrl           peak_bus,
	input  logic               i_queue_full,
	output logic               o_push
);
	import stats_pkg::*;

	//==========================================================================
	// Forwarding stage and broadcast state
	//==========================================================================
	logic       stage_valid;
	sample_t    stage_sample;
	logic       stage_last;
	// Bit 0 energy leg, bit 1 peak leg
	logic [1:0] acked;
	logic [1:0] acked_nxt;
	logic       send_ok;
	logic       retire;

	//==========================================================================
	// Combinational
	//==========================================================================
	// Closing sample waits for a free result slot
	assign send_ok = stage_valid && !(stage_last && i_queue_full);

	// Legs see the same staged word
	assign energy_bus.rdy    = send_ok && !acked[0];
	assign energy_bus.sample = stage_sample;
	assign energy_bus.last   = stage_last;

	assign peak_bus.rdy    = send_ok && !acked[1];
	assign peak_bus.sample = stage_sample;
	assign peak_bus.last   = stage_last;

	// Acks so far plus this cycle's
	assign acked_nxt = acked | {peak_bus.ack, energy_bus.ack};
	// Retire when the second leg comes in
	assign retire = stage_valid && (&acked_nxt);

	// Stage takes a new word when empty or draining now
	assign o_src_ack = i_src_rdy && (!stage_valid || retire);

	//==========================================================================
	// Sequential
	//==========================================================================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			stage_valid <= 1'b0;
		end else if (o_src_ack) begin
			stage_valid <= 1'b1;
		end else if (retire) begin
			stage_valid <= 1'b0;
		end
	end

	// Staged payload, loaded on acceptance only
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			stage_sample <= i_src_sample;
			stage_last   <= i_src_last;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			acked <= 2'b00;
		end else if (retire) begin
			acked <= 2'b00;
		end else begin
			acked <= acked_nxt;
		end
	end

	// One-cycle push after a closing sample leaves the stage
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_push <= 1'b0;
		end else begin
			o_push <= retire && stage_last;
		end
	end

endmodule

`default_nettype wire

// ==== design/energy_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module energy_accum (
	input  logic                       i_clk,
	input  logic                       i_rst,
	stat_bus_if.unit                   bus,
	output logic [`STATS_ENERGY_W-1:0] o_energy
);
	import stats_pkg::*;

	localparam int PROD_W = 2 * `STATS_SAMPLE_W;
	localparam int STEP_W = $clog2(`STATS_SAMPLE_W);

	//==========================================================================
	// Multiplier state
	//==========================================================================
	logic                       busy;
	logic [STEP_W-1:0]          step;
	logic [PROD_W-1:0]          mcand;
	sample_t                    mplier;
	logic [PROD_W-1:0]          prod;
	logic [PROD_W-1:0]          prod_nxt;
	logic [`STATS_ENERGY_W-1:0] sum;
	logic [`STATS_ENERGY_W-1:0] sum_nxt;

	// One partial product per cycle, LSB of multiplier first
	assign prod_nxt = prod + (mplier[0] ? mcand : '0);
	assign sum_nxt  = sum + `STATS_ENERGY_W'(prod_nxt);

	// Ack on the final shift-add step
	assign bus.ack = busy && (step == STEP_W'(`STATS_SAMPLE_W - 1));

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			busy <= 1'b0;
			step <= '0;
		end else if (!busy) begin
			busy <= bus.rdy;
			step <= '0;
		end else begin
			busy <= !bus.ack;
			step <= step + 1'b1;
		end
	end

	// Operands load on a new request, then shift every step
	always_ff @(posedge i_clk) begin
		if (!busy && bus.rdy) begin
			mcand  <= PROD_W'(bus.sample);
			mplier <= bus.sample;
			prod   <= '0;
		end else if (busy) begin
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
			prod   <= prod_nxt;
		end
	end

	// Running sum, handed to the output at frame end
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			sum      <= '0;
			o_energy <= '0;
		end else if (bus.ack) begin
			if (bus.last) begin
				o_energy <= sum_nxt;
				sum      <= '0;
			end else begin
				sum <= sum_nxt;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/peak_track.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module peak_track (
	input  logic                      i_clk,
	input  logic                      i_rst,
	stat_bus_if.unit                  bus,
	output stats_pkg::sample_t        o_peak,
	output logic [`STATS_COUNT_W-1:0] o_count
);
	import stats_pkg::*;

	sample_t                   run_peak;
	sample_t                   peak_nxt;
	logic [`STATS_COUNT_W-1:0] run_count;
	logic [`STATS_COUNT_W-1:0] count_nxt;

	// No latency here, take the sample as soon as offered
	assign bus.ack = bus.rdy;

	assign peak_nxt  = (bus.sample > run_peak) ? bus.sample : run_peak;
	// Hold at all ones
	assign count_nxt = (&run_count) ? run_count : run_count + 1'b1;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			run_peak  <= '0;
			run_count <= '0;
			o_peak    <= '0;
			o_count   <= '0;
		end else if (bus.ack) begin
			if (bus.last) begin
				// Publish, next frame starts from zero
				o_peak    <= peak_nxt;
				o_count   <= count_nxt;
				run_peak  <= '0;
				run_count <= '0;
			end else begin
				run_peak  <= peak_nxt;
				run_count <= count_nxt;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/result_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module result_queue #(
	parameter int DEPTH = `STATS_QUEUE_DEPTH
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_push,
	input  logic [`STATS_ENERGY_W-1:0] i_energy,
	input  stats_pkg::sample_t         i_peak,
	input  logic [`STATS_COUNT_W-1:0]  i_count,
	output logic                       o_full,
	output logic                       o_dst_rdy,
	input  logic                       i_dst_ack,
	output stats_pkg::result_t         o_dst_result
);
	import stats_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	result_t            mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	// Entries held, counts up on push and down on pop
	logic [CNT_W-1:0]   used;
	logic               pop;

	assign pop          = o_dst_rdy && i_dst_ack;
	assign o_dst_rdy    = (used != '0);
	assign o_dst_result = mem[rd_ptr];
	// A push in flight already takes the last slot
	assign o_full = (used == CNT_W'(DEPTH)) || (i_push && used == CNT_W'(DEPTH - 1));

	always_ff @(posedge i_clk) begin
		if (i_push) begin
			mem[wr_ptr] <= '{energy: i_energy, peak: i_peak, count: i_count};
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (i_push && !pop) begin
				used <= used + 1'b1;
			end else if (pop && !i_push) begin
				used <= used - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/stream_stats_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module stream_stats_top (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_src_rdy,
	output logic                       o_src_ack,
	input  logic [`STATS_SAMPLE_W-1:0] i_src_sample,
	input  logic                       i_src_last,
	output logic                       o_dst_rdy,
	input  logic                       i_dst_ack,
	output logic [`STATS_ENERGY_W-1:0] o_dst_energy,
	output logic [`STATS_SAMPLE_W-1:0] o_dst_peak,
	output logic [`STATS_COUNT_W-1:0]  o_dst_count
);
	import stats_pkg::*;

	//==========================================================================
	// Interconnect
	//==========================================================================
	stat_bus_if energy_bus ();
	stat_bus_if peak_bus ();

	logic                       push;
	logic                       queue_full;
	logic [`STATS_ENERGY_W-1:0] energy;
	sample_t                    peak;
	logic [`STATS_COUNT_W-1:0]  count;
	result_t                    dst_result;

	//==========================================================================
	// Units
	//==========================================================================
	stream_ctrl u_ctrl (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_src_rdy    (i_src_rdy),
		.o_src_ack    (o_src_ack),
		.i_src_sample (i_src_sample),
		.i_src_last   (i_src_last),
		.energy_bus   (energy_bus.ctrl),
		.peak_bus     (peak_bus.ctrl),
		.i_queue_full (queue_full),
		.o_push       (push)
	);

	energy_accum u_energy (.i_clk(i_clk), .i_rst(i_rst), .bus(energy_bus.unit), .o_energy(energy));

	peak_track u_peak (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.bus     (peak_bus.unit),
		.o_peak  (peak),
		.o_count (count)
	);

	result_queue #(.DEPTH(`STATS_QUEUE_DEPTH)) u_queue (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_push       (push),
		.i_energy     (energy),
		.i_peak       (peak),
		.i_count      (count),
		.o_full       (queue_full),
		.o_dst_rdy    (o_dst_rdy),
		.i_dst_ack    (i_dst_ack),
		.o_dst_result (dst_result)
	);

	// Result fields out as plain ports
	assign o_dst_energy = dst_result.energy;
	assign o_dst_peak   = dst_result.peak;
	assign o_dst_count  = dst_result.count;

endmodule

`default_nettype wire

// ==== tests/stream_stats_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module stream_stats_checker (
	input  wire                        i_clk,
	input  wire                        i_rst,
	input  wire                        i_src_rdy,
	input  wire                        i_src_ack,
	input  wire                        i_dst_rdy,
	input  wire                        i_dst_ack,
	input  wire [`STATS_ENERGY_W-1:0]  i_dst_energy,
	input  wire [`STATS_SAMPLE_W-1:0]  i_dst_peak,
	input  wire [`STATS_COUNT_W-1:0]   i_dst_count
);

	// Failed assertion count for the testbench summary
	int fail_count = 0;

	//==========================================================================
	// Source side
	//==========================================================================
	// Ack only answers an offer and never twice in a row
	// A staged word needs several cycles before the stage frees up
	ack_needs_rdy: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_src_ack |-> (i_src_rdy && !$past(i_src_ack)))
	else begin
		fail_count = fail_count + 1;
		$error("o_src_ack high without i_src_rdy or while the stage was still full");
	end

	//==========================================================================
	// Result port
	//==========================================================================
	// Offered result held until taken
	dst_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_dst_rdy && !i_dst_ack) |=>
		(i_dst_rdy && $stable({i_dst_energy, i_dst_peak, i_dst_count})))
	else begin
		fail_count = fail_count + 1;
		$error("Result port dropped or changed before i_dst_ack");
	end

	// Quiet during reset
	rst_quiet: assert property (@(posedge i_clk) !i_rst |-> !i_dst_rdy)
	else begin
		fail_count = fail_count + 1;
		$error("o_dst_rdy high during reset");
	end

endmodule

`default_nettype wire

// ==== tests/stream_stats_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_cfg.svh"

module stream_stats_tb;

	localparam int HAND_LEN   = 23;
	localparam int TBL_LEN    = 80;
	localparam int TIMEOUT    = TBL_LEN * 12 + 200;
	// Longer than one sample's trip through the stage
	localparam int STALL_WAIT = 40;
	localparam int RES_W      = `STATS_ENERGY_W + `STATS_SAMPLE_W + `STATS_COUNT_W;
	localparam logic [31:0] LFSR_SEED = 32'hd08e1a82;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	// Each entry is {dst stall, last, sample}
	localparam logic [9:0] HAND_TBL [HAND_LEN] = '{
		{1'b0, 1'b1, 8'd12},
		{1'b0, 1'b0, 8'd3}, {1'b0, 1'b0, 8'd7}, {1'b0, 1'b1, 8'd5},
		{1'b0, 1'b0, 8'd255}, {1'b0, 1'b0, 8'd255}, {1'b0, 1'b0, 8'd255}, {1'b0, 1'b1, 8'd255},
		{1'b0, 1'b0, 8'd0}, {1'b0, 1'b1, 8'd1},
		// Five frames with the result port held off
		{1'b1, 1'b0, 8'd10}, {1'b1, 1'b1, 8'd20}, {1'b1, 1'b0, 8'd30}, {1'b1, 1'b1, 8'd40},
		{1'b1, 1'b0, 8'd200}, {1'b1, 1'b1, 8'd100}, {1'b1, 1'b0, 8'd1}, {1'b1, 1'b1, 8'd2},
		{1'b1, 1'b0, 8'd9}, {1'b1, 1'b1, 8'd8},
		// Closing hand frame with the result port freed partway
		{1'b1, 1'b0, 8'd50}, {1'b0, 1'b0, 8'd60}, {1'b0, 1'b1, 8'd70}
	};

	logic                       i_clk;
	logic                       i_rst;
	logic                       i_src_rdy;
	logic                       o_src_ack;
	logic [`STATS_SAMPLE_W-1:0] i_src_sample;
	logic                       i_src_last;
	logic                       o_dst_rdy;
	logic                       i_dst_ack;
	logic [`STATS_ENERGY_W-1:0] o_dst_energy;
	logic [`STATS_SAMPLE_W-1:0] o_dst_peak;
	logic [`STATS_COUNT_W-1:0]  o_dst_count;

	logic [`STATS_SAMPLE_W-1:0] tbl_sample [TBL_LEN];
	logic                       tbl_last [TBL_LEN];
	logic                       tbl_stall [TBL_LEN];
	logic [RES_W-1:0]           exp_q [$];
	logic [RES_W-1:0]           expected;
	logic [31:0]                lfsr;
	logic                       dst_hold;
	logic                       dst_random;
	logic                       stall_seen;
	int                         errors;
	int                         popped;
	int                         cycles;

	stream_stats_top u_dut (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_src_rdy    (i_src_rdy),
		.o_src_ack    (o_src_ack),
		.i_src_sample (i_src_sample),
		.i_src_last   (i_src_last),
		.o_dst_rdy    (o_dst_rdy),
		.i_dst_ack    (i_dst_ack),
		.o_dst_energy (o_dst_energy),
		.o_dst_peak   (o_dst_peak),
		.o_dst_count  (o_dst_count)
	);

	bind stream_stats_top stream_stats_checker u_checker (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_src_rdy    (i_src_rdy),
		.i_src_ack    (o_src_ack),
		.i_dst_rdy    (o_dst_rdy),
		.i_dst_ack    (i_dst_ack),
		.i_dst_energy (o_dst_energy),
		.i_dst_peak   (o_dst_peak),
		.i_dst_count  (o_dst_count)
	);

	initial i_clk = 1'b0;
	always #50 i_clk = ~i_clk;

	//==========================================================================
	// Random bits
	//==========================================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	//==========================================================================
	// Table and reference model
	//==========================================================================
	task automatic load_table();
		int run_energy;
		int run_peak;
		int run_count;
		run_energy = 0;
		run_peak = 0;
		run_count = 0;
		for (int i = 0; i < TBL_LEN; i++) begin
			if (i < HAND_LEN) begin
				tbl_sample[i] = HAND_TBL[i][7:0];
				tbl_last[i]   = HAND_TBL[i][8];
				tbl_stall[i]  = HAND_TBL[i][9];
			end else begin
				tbl_sample[i] = 8'(take_bits(8));
				// About eight samples per frame and the last entry closes one
				tbl_last[i]   = (take_bits(3) == 0) || (i == TBL_LEN - 1);
				tbl_stall[i]  = 1'b0;
			end
			// Sum of squares plus running max and saturating count
			run_energy = run_energy + tbl_sample[i] * tbl_sample[i];
			if (tbl_sample[i] > run_peak)
				run_peak = tbl_sample[i];
			if (run_count < (1 << `STATS_COUNT_W) - 1)
				run_count = run_count + 1;
			if (tbl_last[i]) begin
				exp_q.push_back({run_energy[`STATS_ENERGY_W-1:0],
					run_peak[`STATS_SAMPLE_W-1:0], run_count[`STATS_COUNT_W-1:0]});
				run_energy = 0;
				run_peak = 0;
				run_count = 0;
			end
		end
	endtask

	//==========================================================================
	// Drivers
	//==========================================================================
	// Result side ack for the coming cycle on each falling edge
	task automatic next_cycle();
		@(negedge i_clk);
		if (dst_hold)
			i_dst_ack = 1'b0;
		else if (dst_random)
			i_dst_ack = 1'(take_bits(1));
		else
			i_dst_ack = 1'b1;
	endtask

	task automatic send_entry(input int idx);
		int   waited;
		int   gap;
		logic accepted;
		waited = 0;
		accepted = 1'b0;
		// Gaps reach past a sample's trip so the stage also runs empty
		gap = dst_random ? int'(take_bits(4)) : 0;
		if (gap > 0) begin
			i_src_rdy = 1'b0;
			repeat (gap) next_cycle();
		end
		dst_hold     = tbl_stall[idx];
		i_src_rdy    = 1'b1;
		i_src_sample = tbl_sample[idx];
		i_src_last   = tbl_last[idx];
		while (!accepted) begin
			@(posedge i_clk);
			accepted = o_src_ack;
			next_cycle();
			waited++;
			// Long source stall releases the result port
			if (!accepted && dst_hold && waited >= STALL_WAIT) begin
				assert (o_dst_rdy) else begin
					errors++;
					$display("Source stalled at %0t while the result queue was empty", $time);
				end
				stall_seen = 1'b1;
				dst_hold = 1'b0;
			end
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	//==========================================================================
	// Scoreboard on each pop
	//==========================================================================
	always @(posedge i_clk) begin
		if (i_rst && o_dst_rdy && i_dst_ack) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Result popped at %0t with no frame outstanding", $time);
			end
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				check_field("o_dst_energy", 32'(o_dst_energy),
					32'(expected[RES_W-1 -: `STATS_ENERGY_W]));
				check_field("o_dst_peak", 32'(o_dst_peak),
					32'(expected[`STATS_COUNT_W +: `STATS_SAMPLE_W]));
				check_field("o_dst_count", 32'(o_dst_count),
					32'(expected[`STATS_COUNT_W-1:0]));
				popped++;
			end
		end
	end

	// Watchdog
	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, %0d results still outstanding",
				cycles, exp_q.size());
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin
		i_rst        = 1'b0;
		i_src_rdy    = 1'b0;
		i_src_sample = '0;
		i_src_last   = 1'b0;
		i_dst_ack    = 1'b0;
		dst_hold     = 1'b0;
		dst_random   = 1'b0;
		stall_seen   = 1'b0;
		errors       = 0;
		popped       = 0;
		cycles       = 0;
		lfsr         = LFSR_SEED;
		load_table();
		repeat (5) @(negedge i_clk);
		i_rst = 1'b1;
		assert (!o_src_ack && !o_dst_rdy) else begin
			errors++;
			$display("Handshake outputs high right after reset");
		end
		// Hand part first and then random gaps and acks
		for (int i = 0; i < TBL_LEN; i++) begin
			dst_random = (i >= HAND_LEN);
			send_entry(i);
		end
		i_src_rdy  = 1'b0;
		i_src_last = 1'b0;
		dst_hold   = 1'b0;
		while (exp_q.size() != 0)
			next_cycle();
		repeat (4) next_cycle();
		assert (stall_seen) else begin
			errors++;
			$display("Back-pressure never held the source off");
		end
		$display("Errors: %0d scoreboard, %0d assertion; results checked: %0d",
			errors, u_dut.u_checker.fail_count, popped);
		if (errors == 0 && u_dut.u_checker.fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/stats_pkg.sv
design/stat_bus_if.sv
design/stream_ctrl.sv
design/energy_accum.sv
design/peak_track.sv
design/result_queue.sv
design/stream_stats_top.sv
tests/stream_stats_checker.sv
tests/stream_stats_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= stream_stats_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
RUN_FLAGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
